// ==== hw/usb_out_pkg.sv ====
// USB OUT engine definitions

package usb_out_pkg;

  ////////////////////////////////
  // Field widths
  ////////////////////////////////

  // PID nibble without the check bits
  parameter int unsigned PidW     = 4;
  parameter int unsigned DevAddrW = 7;
  parameter int unsigned EpNumW   = 4;
  parameter int unsigned ByteW    = 8;

  // 17 bit times at 4 clocks per bit on the 48 MHz clock
  parameter int unsigned DefaultAckTimeoutCnt = 17 * 4;

  ////////////////////////////////
  // Encodings
  ////////////////////////////////

  // PID codes as seen on rx_pid_i and driven on tx_pid_o
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,
    UsbPidIn    = 4'b1001,
    UsbPidSetup = 4'b1101,
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    UsbPidAck   = 4'b0010,
    UsbPidNak   = 4'b1010,
    UsbPidStall = 4'b1110
  } usb_pid_e;

  // PID type from the two low PID bits
  typedef enum logic [1:0] {
    UsbPidTypeToken     = 2'b01,
    UsbPidTypeData      = 2'b11,
    UsbPidTypeHandshake = 2'b10
  } usb_pid_type_e;

  // OUT/SETUP transaction states
  typedef enum logic [1:0] {
    StIdle,
    StRcvdOut,
    StRcvdDataStart,
    StRcvdDataEnd
  } out_xact_state_e;

endpackage

// ==== hw/usb_rx_event_if.sv ====
// Receive event bundle
`timescale 1ns/1ps

interface usb_rx_event_if;
  import usb_out_pkg::*;

  // Packet end events, one cycle, qualified by rx_pkt_end_i
  logic              out_tok;
  logic              setup_tok;
  logic              data_ok;
  // Invalid packet or a non-data packet
  logic              pkt_bad;
  // Data PID toggle bit disagrees with the stored toggle
  logic              bad_toggle;

  // Endpoint lookup, valid at all times
  logic              ep_active;
  logic              ep_is_control;
  // Zero when the endpoint is not implemented
  logic [EpNumW-1:0] ep_num;

  modport decoder (
    output out_tok, setup_tok, data_ok, pkt_bad, bad_toggle,
    output ep_active, ep_is_control, ep_num
  );

  modport fsm (
    input out_tok, setup_tok, data_ok, pkt_bad, bad_toggle,
    input ep_active, ep_is_control, ep_num
  );

endinterface

// ==== hw/usb_out_rx_decode.sv ====
// Receive packet classifier
`timescale 1ns/1ps

module usb_out_rx_decode #(
  parameter int unsigned NumOutEps = 2
) (
  input  logic                             clk_48mhz_i,
  input  logic                             rst_ni,
  input  logic                             link_reset_i,
  input  logic [usb_out_pkg::DevAddrW-1:0] dev_addr_i,
  input  logic                             rx_pkt_end_i,
  input  logic                             rx_pkt_valid_i,
  input  logic [usb_out_pkg::PidW-1:0]     rx_pid_i,
  input  logic [usb_out_pkg::DevAddrW-1:0] rx_addr_i,
  input  logic [usb_out_pkg::EpNumW-1:0]   rx_endp_i,
  input  logic [NumOutEps-1:0]             out_ep_enabled_i,
  input  logic [NumOutEps-1:0]             out_ep_control_i,
  input  logic                             accept_pkt_i,
  input  logic [usb_out_pkg::EpNumW-1:0]   accept_ep_i,
  output logic [NumOutEps-1:0]             out_data_toggle_o,
  usb_rx_event_if.decoder                  ev
);
  import usb_out_pkg::*;

  // Index width for NumOutEps wide vectors
  localparam int unsigned EpIdxW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;

  usb_pid_e             rx_pid;
  usb_pid_type_e        rx_pid_type;
  logic                 token_hit;
  logic                 is_data_pid;
  logic                 ep_in_hw;
  logic [EpIdxW-1:0]    ep_idx;
  logic [EpIdxW-1:0]    acc_idx;
  logic [NumOutEps-1:0] toggle_q;

  ////////////////////////////////
  // Packet classification
  ////////////////////////////////

  assign rx_pid      = usb_pid_e'(rx_pid_i);
  assign rx_pid_type = usb_pid_type_e'(rx_pid_i[1:0]);
  assign is_data_pid = (rx_pid == UsbPidData0) || (rx_pid == UsbPidData1);

  // Good token addressed to this device
  assign token_hit = rx_pkt_end_i && rx_pkt_valid_i &&
                     (rx_pid_type == UsbPidTypeToken) && (rx_addr_i == dev_addr_i);

  assign ev.out_tok   = token_hit && (rx_pid == UsbPidOut);
  assign ev.setup_tok = token_hit && (rx_pid == UsbPidSetup);
  assign ev.data_ok   = rx_pkt_end_i && rx_pkt_valid_i && is_data_pid;
  // Bad CRC or anything that is not DATA0/DATA1
  assign ev.pkt_bad   = rx_pkt_end_i && (!rx_pkt_valid_i || !is_data_pid);

  ////////////////////////////////
  // Endpoint lookup
  ////////////////////////////////

  // Endpoint field still holds the last token while data arrives
  assign ep_in_hw  = 32'(rx_endp_i) < NumOutEps;
  assign ev.ep_num = ep_in_hw ? rx_endp_i : '0;
  assign ep_idx    = ev.ep_num[EpIdxW-1:0];
  assign acc_idx   = accept_ep_i[EpIdxW-1:0];

  assign ev.ep_active     = ep_in_hw && out_ep_enabled_i[ep_idx];
  assign ev.ep_is_control = out_ep_control_i[ep_idx];

  // Bit 3 of a data PID is the toggle (DATA1)
  assign ev.bad_toggle = ev.data_ok && ev.ep_active && (rx_pid_i[3] != toggle_q[ep_idx]);

  ////////////////////////////////
  // Data toggles
  ////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      // Bus reset restarts every endpoint at DATA0
      toggle_q <= '0;
    end else if (ev.setup_tok && ev.ep_active) begin
      // SETUP always begins with DATA0
      toggle_q[ep_idx] <= 1'b0;
    end else if (accept_pkt_i) begin
      // Accepted packet flips the toggle of the current endpoint
      toggle_q[acc_idx] <= ~toggle_q[acc_idx];
    end
  end

  assign out_data_toggle_o = toggle_q;

endmodule

// ==== hw/usb_out_xact_fsm.sv ====
// OUT transaction state machine
`timescale 1ns/1ps

module usb_out_xact_fsm #(
  parameter int unsigned NumOutEps     = 2,
  parameter int unsigned AckTimeoutCnt = usb_out_pkg::DefaultAckTimeoutCnt
) (
  input  logic                           clk_48mhz_i,
  input  logic                           rst_ni,
  input  logic                           link_reset_i,
  input  logic                           rx_pkt_start_i,
  input  logic [NumOutEps-1:0]           out_ep_full_i,
  input  logic [NumOutEps-1:0]           out_ep_stall_i,
  input  logic                           nak_pending_i,
  usb_rx_event_if.fsm                    ev,
  output logic [usb_out_pkg::EpNumW-1:0] out_ep_current_o,
  output logic                           out_ep_newpkt_o,
  output logic [NumOutEps-1:0]           out_ep_setup_o,
  output logic                           out_ep_acked_o,
  output logic                           out_ep_rollback_o,
  output logic                           tx_pkt_start_o,
  output logic [usb_out_pkg::PidW-1:0]   tx_pid_o,
  output logic                           accept_pkt_o,
  output logic [usb_out_pkg::EpNumW-1:0] accept_ep_o,
  output logic                           in_data_phase_o,
  output logic                           clear_put_o
);
  import usb_out_pkg::*;

  localparam int unsigned EpIdxW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;
  localparam int unsigned CntW   = $clog2(AckTimeoutCnt + 1);

  out_xact_state_e   state_q;
  out_xact_state_e   state_d;
  logic [CntW-1:0]   cnt_q;
  logic [CntW-1:0]   cnt_d;
  logic              xact_start;
  logic              setup_xact_q;
  logic              pkt_accept;
  logic              rollback;
  logic              store_fail;
  logic [EpIdxW-1:0] cur_idx;
  logic [EpIdxW-1:0] start_idx;

  assign cur_idx   = out_ep_current_o[EpIdxW-1:0];
  assign start_idx = ev.ep_num[EpIdxW-1:0];

  // Endpoint cannot take this packet
  assign store_fail = nak_pending_i || out_ep_full_i[cur_idx];

  ////////////////////////////////
  // Next state and response
  ////////////////////////////////

  always_comb begin
    state_d        = state_q;
    cnt_d          = CntW'(AckTimeoutCnt);
    xact_start     = 1'b0;
    pkt_accept     = 1'b0;
    rollback       = 1'b0;
    tx_pkt_start_o = 1'b0;
    tx_pid_o       = '0;

    unique case (state_q)
      StIdle: begin
        // Unimplemented endpoints and SETUP to non-control endpoints are ignored
        if (ev.ep_active && (ev.out_tok || (ev.setup_tok && ev.ep_is_control))) begin
          state_d    = StRcvdOut;
          xact_start = 1'b1;
        end
      end

      StRcvdOut: begin
        // Host data packet must start within the turnaround window
        cnt_d = cnt_q - 1'b1;
        if (rx_pkt_start_i) begin
          state_d = StRcvdDataStart;
        end else if (cnt_q == '0) begin
          state_d = StIdle;
        end
      end

      StRcvdDataStart: begin
        if (ev.bad_toggle && !out_ep_stall_i[cur_idx]) begin
          // Repeat of a packet whose ACK was lost, so ACK again and drop it
          state_d        = StIdle;
          rollback       = 1'b1;
          tx_pkt_start_o = 1'b1;
          tx_pid_o       = UsbPidAck;
        end else if (ev.pkt_bad) begin
          // Silent drop without a handshake
          state_d  = StIdle;
          rollback = 1'b1;
        end else if (ev.data_ok) begin
          state_d = StRcvdDataEnd;
        end
      end

      StRcvdDataEnd: begin
        state_d = StIdle;
        if (setup_xact_q) begin
          // SETUP that cannot be stored gets no answer at all
          if (!store_fail) begin
            tx_pkt_start_o = 1'b1;
            tx_pid_o       = UsbPidAck;
            pkt_accept     = 1'b1;
          end
        end else if (out_ep_stall_i[cur_idx]) begin
          tx_pkt_start_o = 1'b1;
          tx_pid_o       = UsbPidStall;
        end else if (store_fail) begin
          // Host retries later
          tx_pkt_start_o = 1'b1;
          tx_pid_o       = UsbPidNak;
          rollback       = 1'b1;
        end else begin
          tx_pkt_start_o = 1'b1;
          tx_pid_o       = UsbPidAck;
          pkt_accept     = 1'b1;
        end
      end

      default: state_d = StIdle;
    endcase
  end

  ////////////////////////////////
  // State and transaction registers
  ////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      cnt_q   <= CntW'(AckTimeoutCnt);
    end else begin
      state_q <= link_reset_i ? StIdle : state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Endpoint and SETUP flag latched at the token
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_newpkt_o  <= 1'b0;
      out_ep_current_o <= '0;
      out_ep_setup_o   <= '0;
      setup_xact_q     <= 1'b0;
    end else begin
      out_ep_newpkt_o <= xact_start;
      if (xact_start) begin
        out_ep_current_o          <= ev.ep_num;
        out_ep_setup_o[start_idx] <= ev.setup_tok;
        setup_xact_q              <= ev.setup_tok;
      end
    end
  end

  assign out_ep_acked_o    = pkt_accept;
  assign out_ep_rollback_o = rollback;
  assign accept_pkt_o      = pkt_accept;
  assign accept_ep_o       = out_ep_current_o;
  assign in_data_phase_o   = (state_q == StRcvdDataStart);
  assign clear_put_o       = (state_q == StRcvdOut);

  ////////////////////////////////
  // Assertions
  ////////////////////////////////

  // State register never holds an unknown encoding
  state_legal_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !$isunknown(state_q));

  // Only handshakes leave this engine
  tx_pid_handshake_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    tx_pkt_start_o |-> tx_pid_o inside {UsbPidAck, UsbPidNak, UsbPidStall});

  acked_rollback_excl_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(out_ep_acked_o && out_ep_rollback_o));

endmodule

// ==== hw/usb_out_data_path.sv ====
// OUT data forwarding
`timescale 1ns/1ps

module usb_out_data_path #(
  parameter int unsigned NumOutEps         = 2,
  parameter int unsigned MaxOutPktSizeByte = 32,
  localparam int unsigned PktW             = $clog2(MaxOutPktSizeByte)
) (
  input  logic                           clk_48mhz_i,
  input  logic                           rst_ni,
  input  logic                           rx_data_put_i,
  input  logic [usb_out_pkg::ByteW-1:0]  rx_data_i,
  input  logic                           in_data_phase_i,
  input  logic                           clear_put_i,
  input  logic [NumOutEps-1:0]           out_ep_full_i,
  input  logic [usb_out_pkg::EpNumW-1:0] ep_idx_i,
  output logic [usb_out_pkg::ByteW-1:0]  out_ep_data_o,
  output logic                           out_ep_data_put_o,
  output logic [PktW-1:0]                out_ep_put_addr_o,
  output logic                           nak_pending_o
);

  localparam int unsigned EpIdxW = (NumOutEps > 1) ? $clog2(NumOutEps) : 1;

  logic [EpIdxW-1:0] ep_idx;
  logic              addr_inc;

  // Current endpoint is forced to 0 when unimplemented
  assign ep_idx = ep_idx_i[EpIdxW-1:0];

  ////////////////////////////////
  // Byte and put strobe
  ////////////////////////////////

  // Holds the last received byte
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_put_i) begin
      out_ep_data_o <= rx_data_i;
    end
  end

  // Put follows the rx strobe by one cycle, data phase only
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_data_put_o <= 1'b0;
    end else begin
      out_ep_data_put_o <= in_data_phase_i && rx_data_put_i;
    end
  end

  ////////////////////////////////
  // Put offset
  ////////////////////////////////

  // Stop when a NAK is coming or the offset is at its top
  assign addr_inc = out_ep_data_put_o && !nak_pending_o && !(&out_ep_put_addr_o);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_put_addr_o <= '0;
    end else if (clear_put_i) begin
      out_ep_put_addr_o <= '0;
    end else if (in_data_phase_i && addr_inc) begin
      out_ep_put_addr_o <= out_ep_put_addr_o + 1'b1;
    end
  end

  // Sticky NAK once a byte lands on a full endpoint
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_pending_o <= 1'b0;
    end else if (!in_data_phase_i) begin
      nak_pending_o <= 1'b0;
    end else if (out_ep_data_put_o && out_ep_full_i[ep_idx]) begin
      nak_pending_o <= 1'b1;
    end
  end

  // Saturation keeps a long packet from wrapping the offset
  put_addr_no_wrap_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    (in_data_phase_i && (out_ep_put_addr_o != '0)) |=> (out_ep_put_addr_o != '0));

endmodule

// ==== hw/usb_out_pe.sv ====
// USB OUT protocol engine
`timescale 1ns/1ps

module usb_out_pe #(
  parameter int unsigned NumOutEps         = 2,
  parameter int unsigned MaxOutPktSizeByte = 32,
  parameter int unsigned AckTimeoutCnt     = usb_out_pkg::DefaultAckTimeoutCnt,
  localparam int unsigned PktW             = $clog2(MaxOutPktSizeByte)
) (
  input  logic                             clk_48mhz_i,
  input  logic                             rst_ni,
  input  logic                             link_reset_i,
  input  logic [usb_out_pkg::DevAddrW-1:0] dev_addr_i,
  // Receive side strobes and fields
  input  logic                             rx_pkt_start_i,
  input  logic                             rx_pkt_end_i,
  input  logic                             rx_pkt_valid_i,
  input  logic [usb_out_pkg::PidW-1:0]     rx_pid_i,
  input  logic [usb_out_pkg::DevAddrW-1:0] rx_addr_i,
  input  logic [usb_out_pkg::EpNumW-1:0]   rx_endp_i,
  input  logic                             rx_data_put_i,
  input  logic [usb_out_pkg::ByteW-1:0]    rx_data_i,
  // Endpoint configuration and status
  input  logic [NumOutEps-1:0]             out_ep_enabled_i,
  input  logic [NumOutEps-1:0]             out_ep_control_i,
  input  logic [NumOutEps-1:0]             out_ep_full_i,
  input  logic [NumOutEps-1:0]             out_ep_stall_i,
  // Endpoint side
  output logic [usb_out_pkg::EpNumW-1:0]   out_ep_current_o,
  output logic                             out_ep_data_put_o,
  output logic [PktW-1:0]                  out_ep_put_addr_o,
  output logic [usb_out_pkg::ByteW-1:0]    out_ep_data_o,
  output logic                             out_ep_newpkt_o,
  output logic                             out_ep_acked_o,
  output logic                             out_ep_rollback_o,
  output logic [NumOutEps-1:0]             out_ep_setup_o,
  output logic [NumOutEps-1:0]             out_data_toggle_o,
  // Handshake to the transmit side
  output logic                             tx_pkt_start_o,
  output logic [usb_out_pkg::PidW-1:0]     tx_pid_o
);
  import usb_out_pkg::*;

  logic              accept_pkt;
  logic [EpNumW-1:0] accept_ep;
  logic              in_data_phase;
  logic              clear_put;
  logic              nak_pending;

  // Classified events from decoder to FSM
  usb_rx_event_if ev_if ();

  usb_out_rx_decode #(
    .NumOutEps (NumOutEps)
  ) u_rx_decode (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .link_reset_i      (link_reset_i),
    .dev_addr_i        (dev_addr_i),
    .rx_pkt_end_i      (rx_pkt_end_i),
    .rx_pkt_valid_i    (rx_pkt_valid_i),
    .rx_pid_i          (rx_pid_i),
    .rx_addr_i         (rx_addr_i),
    .rx_endp_i         (rx_endp_i),
    .out_ep_enabled_i  (out_ep_enabled_i),
    .out_ep_control_i  (out_ep_control_i),
    .accept_pkt_i      (accept_pkt),
    .accept_ep_i       (accept_ep),
    .out_data_toggle_o (out_data_toggle_o),
    .ev                (ev_if.decoder)
  );

  usb_out_xact_fsm #(
    .NumOutEps     (NumOutEps),
    .AckTimeoutCnt (AckTimeoutCnt)
  ) u_xact_fsm (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .link_reset_i      (link_reset_i),
    .rx_pkt_start_i    (rx_pkt_start_i),
    .out_ep_full_i     (out_ep_full_i),
    .out_ep_stall_i    (out_ep_stall_i),
    .nak_pending_i     (nak_pending),
    .ev                (ev_if.fsm),
    .out_ep_current_o  (out_ep_current_o),
    .out_ep_newpkt_o   (out_ep_newpkt_o),
    .out_ep_setup_o    (out_ep_setup_o),
    .out_ep_acked_o    (out_ep_acked_o),
    .out_ep_rollback_o (out_ep_rollback_o),
    .tx_pkt_start_o    (tx_pkt_start_o),
    .tx_pid_o          (tx_pid_o),
    .accept_pkt_o      (accept_pkt),
    .accept_ep_o       (accept_ep),
    .in_data_phase_o   (in_data_phase),
    .clear_put_o       (clear_put)
  );

  usb_out_data_path #(
    .NumOutEps         (NumOutEps),
    .MaxOutPktSizeByte (MaxOutPktSizeByte)
  ) u_data_path (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .rx_data_put_i     (rx_data_put_i),
    .rx_data_i         (rx_data_i),
    .in_data_phase_i   (in_data_phase),
    .clear_put_i       (clear_put),
    .out_ep_full_i     (out_ep_full_i),
    .ep_idx_i          (out_ep_current_o),
    .out_ep_data_o     (out_ep_data_o),
    .out_ep_data_put_o (out_ep_data_put_o),
    .out_ep_put_addr_o (out_ep_put_addr_o),
    .nak_pending_o     (nak_pending)
  );

endmodule

// ==== bench/tb_usb_out_pe.sv ====
// OUT engine testbench
`timescale 1ns/1ps

module tb_usb_out_pe;
  import usb_out_pkg::*;

  localparam int NumFields = 13;
  localparam int MaxTests  = 32;
  // Cycles allowed for a handshake after the data packet end
  localparam int RespWait  = 8;
  localparam logic [6:0] DevAddr   = 7'h2a;
  localparam logic [1:0] EpEnabled = 2'b11;
  // Only endpoint 0 takes SETUP
  localparam logic [1:0] EpControl = 2'b01;

  logic       clk_48mhz;
  logic       rst_n;
  logic       link_reset;
  logic [6:0] dev_addr;
  logic       rx_pkt_start;
  logic       rx_pkt_end;
  logic       rx_pkt_valid;
  logic [3:0] rx_pid;
  logic [6:0] rx_addr;
  logic [3:0] rx_endp;
  logic       rx_data_put;
  logic [7:0] rx_data;
  logic [1:0] out_ep_enabled;
  logic [1:0] out_ep_control;
  logic [1:0] out_ep_full;
  logic [1:0] out_ep_stall;
  logic [3:0] out_ep_current;
  logic       out_ep_data_put;
  logic [4:0] out_ep_put_addr;
  logic [7:0] out_ep_data;
  logic       out_ep_newpkt;
  logic       out_ep_acked;
  logic       out_ep_rollback;
  logic [1:0] out_ep_setup;
  logic [1:0] out_data_toggle;
  logic       tx_pkt_start;
  logic [3:0] tx_pid;

  // Line count first, then NumFields values per transaction
  logic [7:0]  pat_mem [0:MaxTests*NumFields];
  logic [31:0] lcg_state = 32'd97;
  int          err_cnt   = 0;
  int          pass_cnt  = 0;

  // Monitor totals, only ever incremented
  int unsigned newpkt_total   = 0;
  int unsigned tx_total       = 0;
  int unsigned acked_total    = 0;
  int unsigned rollback_total = 0;
  logic [3:0]  last_tx_pid;
  logic [3:0]  last_current;
  logic [1:0]  last_setup;
  logic [7:0]  put_data_q [$];
  logic [4:0]  put_addr_q [$];

  usb_out_pe DUT (
    .clk_48mhz_i       (clk_48mhz),
    .rst_ni            (rst_n),
    .link_reset_i      (link_reset),
    .dev_addr_i        (dev_addr),
    .rx_pkt_start_i    (rx_pkt_start),
    .rx_pkt_end_i      (rx_pkt_end),
    .rx_pkt_valid_i    (rx_pkt_valid),
    .rx_pid_i          (rx_pid),
    .rx_addr_i         (rx_addr),
    .rx_endp_i         (rx_endp),
    .rx_data_put_i     (rx_data_put),
    .rx_data_i         (rx_data),
    .out_ep_enabled_i  (out_ep_enabled),
    .out_ep_control_i  (out_ep_control),
    .out_ep_full_i     (out_ep_full),
    .out_ep_stall_i    (out_ep_stall),
    .out_ep_current_o  (out_ep_current),
    .out_ep_data_put_o (out_ep_data_put),
    .out_ep_put_addr_o (out_ep_put_addr),
    .out_ep_data_o     (out_ep_data),
    .out_ep_newpkt_o   (out_ep_newpkt),
    .out_ep_acked_o    (out_ep_acked),
    .out_ep_rollback_o (out_ep_rollback),
    .out_ep_setup_o    (out_ep_setup),
    .out_data_toggle_o (out_data_toggle),
    .tx_pkt_start_o    (tx_pkt_start),
    .tx_pid_o          (tx_pid)
  );

  initial begin
    clk_48mhz = 1'b0;
    forever #10 clk_48mhz = ~clk_48mhz;
  end

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  // Falling edge, where every DUT output has settled
  always @(negedge clk_48mhz) begin
    if (rst_n) begin
      if (out_ep_newpkt) begin
        newpkt_total++;
        last_current = out_ep_current;
        last_setup   = out_ep_setup;
      end
      if (tx_pkt_start) begin
        tx_total++;
        last_tx_pid = tx_pid;
      end
      if (out_ep_acked) begin
        acked_total++;
      end
      if (out_ep_rollback) begin
        rollback_total++;
      end
      if (out_ep_data_put) begin
        put_data_q.push_back(out_ep_data);
        put_addr_q.push_back(out_ep_put_addr);
      end
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [1:0] ep_mask(logic [3:0] endp);
    return (endp < 4'd2) ? (2'b01 << endp) : 2'b00;
  endfunction

  // Token reaches the endpoint side only for a live endpoint of this device
  function automatic bit newpkt_expected(logic [3:0] pid, logic [6:0] addr, logic [3:0] endp);
    bit hit;
    hit = (addr == DevAddr) && (endp < 4'd2) && EpEnabled[endp[0]];
    return hit && ((pid == UsbPidOut) || ((pid == UsbPidSetup) && EpControl[endp[0]]));
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic pulse_link_reset();
    @(posedge clk_48mhz);
    link_reset <= 1'b1;
    @(posedge clk_48mhz);
    link_reset <= 1'b0;
    @(negedge clk_48mhz);
    check_value("out_data_toggle_o", out_data_toggle, 0);
    @(posedge clk_48mhz);
  endtask

  task automatic run_transaction(input int idx);
    int          base;
    int          nbytes;
    int          gap;
    int          k;
    int          errs_before;
    int          put_0;
    int unsigned newpkt_0;
    int unsigned tx_0;
    int unsigned acked_0;
    int unsigned rollback_0;
    logic [3:0]  tok_pid;
    logic [6:0]  addr;
    logic [3:0]  endp;
    logic [3:0]  exp_tx;
    logic [1:0]  exp_resp;
    logic [7:0]  b;
    logic [7:0]  exp_bytes [$];
    bit          exp_newpkt;
    bit          got;

    base        = 1 + idx * NumFields;
    tok_pid     = pat_mem[base][3:0];
    addr        = pat_mem[base+1][6:0];
    endp        = pat_mem[base+2][3:0];
    nbytes      = pat_mem[base+4];
    gap         = pat_mem[base+9];
    exp_tx      = pat_mem[base+10][3:0];
    exp_resp    = pat_mem[base+11][1:0];
    exp_newpkt  = newpkt_expected(tok_pid, addr, endp);
    errs_before = err_cnt;

    if (pat_mem[base+8][0]) begin
      pulse_link_reset();
    end
    newpkt_0   = newpkt_total;
    tx_0       = tx_total;
    acked_0    = acked_total;
    rollback_0 = rollback_total;
    put_0      = put_data_q.size();

    // Token, full and stall stay put until the transaction is over
    @(posedge clk_48mhz);
    out_ep_full  <= pat_mem[base+6][0] ? ep_mask(endp) : 2'b00;
    out_ep_stall <= pat_mem[base+7][0] ? ep_mask(endp) : 2'b00;
    rx_pkt_end   <= 1'b1;
    rx_pkt_valid <= 1'b1;
    rx_pid       <= tok_pid;
    rx_addr      <= addr;
    rx_endp      <= endp;
    @(posedge clk_48mhz);
    rx_pkt_end   <= 1'b0;
    repeat (gap) @(posedge clk_48mhz);
    rx_pkt_start <= 1'b1;

    for (k = 0; k < nbytes; k++) begin
      @(posedge clk_48mhz);
      lcg_state = lcg_next(lcg_state);
      b = lcg_state[23:16];
      exp_bytes.push_back(b);
      rx_pkt_start <= 1'b0;
      rx_data_put  <= 1'b1;
      rx_data      <= b;
    end

    // Data packet end, address and endpoint fields still from the token
    @(posedge clk_48mhz);
    rx_pkt_start <= 1'b0;
    rx_data_put  <= 1'b0;
    rx_pkt_end   <= 1'b1;
    rx_pkt_valid <= !pat_mem[base+5][0];
    rx_pid       <= pat_mem[base+3][3:0];
    @(posedge clk_48mhz);
    rx_pkt_end   <= 1'b0;
    rx_pkt_valid <= 1'b0;

    got = (tx_total + acked_total + rollback_total) != (tx_0 + acked_0 + rollback_0);
    for (k = 0; k < RespWait && !got; k++) begin
      @(posedge clk_48mhz);
      got = (tx_total + acked_total + rollback_total) != (tx_0 + acked_0 + rollback_0);
    end
    assert (got || ((exp_tx == 4'h0) && (exp_resp == 2'd0))) else begin
      $display("test %0d: no handshake or rollback within %0d cycles", idx, RespWait);
      err_cnt++;
    end
    repeat (2) @(posedge clk_48mhz);
    @(negedge clk_48mhz);

    check_value("out_ep_newpkt_o count", newpkt_total - newpkt_0, exp_newpkt);
    if (exp_newpkt) begin
      check_value("out_ep_current_o", last_current, endp);
      check_value("out_ep_setup_o bit", last_setup[endp[0]], tok_pid == UsbPidSetup);
    end
    check_value("tx_pkt_start_o count", tx_total - tx_0, exp_tx != 4'h0);
    if (exp_tx != 4'h0) begin
      check_value("tx_pid_o", last_tx_pid, exp_tx);
    end
    check_value("out_ep_acked_o count", acked_total - acked_0, exp_resp == 2'd1);
    check_value("out_ep_rollback_o count", rollback_total - rollback_0, exp_resp == 2'd2);
    check_value("out_data_toggle_o", out_data_toggle, pat_mem[base+12][1:0]);

    // Bytes in order at offsets from 0 when accepted
    if (exp_resp == 2'd1) begin
      check_value("out_ep_data_put_o count", put_data_q.size() - put_0, nbytes);
      for (k = 0; (k < nbytes) && (put_0 + k < put_data_q.size()); k++) begin
        check_value("out_ep_data_o", put_data_q[put_0+k], exp_bytes[k]);
        check_value("out_ep_put_addr_o", put_addr_q[put_0+k], k);
      end
    end

    @(posedge clk_48mhz);
    out_ep_full  <= 2'b00;
    out_ep_stall <= 2'b00;
    if (err_cnt == errs_before) begin
      pass_cnt++;
    end
    $display("test %0d: %s", idx, (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int num_tests;
    int t;

    rst_n          <= 1'b0;
    link_reset     <= 1'b0;
    dev_addr       <= DevAddr;
    rx_pkt_start   <= 1'b0;
    rx_pkt_end     <= 1'b0;
    rx_pkt_valid   <= 1'b0;
    rx_pid         <= 4'h0;
    rx_addr        <= 7'h00;
    rx_endp        <= 4'h0;
    rx_data_put    <= 1'b0;
    rx_data        <= 8'h00;
    out_ep_enabled <= EpEnabled;
    out_ep_control <= EpControl;
    out_ep_full    <= 2'b00;
    out_ep_stall   <= 2'b00;

    $readmemh("bench/usb_out_patterns.txt", pat_mem);
    num_tests = pat_mem[0];

    repeat (16) @(posedge clk_48mhz);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk_48mhz);
    @(negedge clk_48mhz);
    // Quiet outputs straight after reset
    check_value("tx_pkt_start_o", tx_pkt_start, 0);
    check_value("tx_pid_o", tx_pid, 0);
    check_value("out_data_toggle_o", out_data_toggle, 0);
    @(posedge clk_48mhz);

    assert ((num_tests > 0) && (num_tests <= MaxTests)) else begin
      $display("pattern file gives no usable transaction count");
      err_cnt++;
    end
    for (t = 0; (t < num_tests) && (t < MaxTests); t++) begin
      run_transaction(t);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             num_tests, pass_cnt, num_tests - pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== usb_out_pe.f ====
hw/usb_out_pkg.sv
hw/usb_rx_event_if.sv
hw/usb_out_rx_decode.sv
hw/usb_out_xact_fsm.sv
hw/usb_out_data_path.sv
hw/usb_out_pe.sv
bench/tb_usb_out_pe.sv

// ==== Bender.yml ====
package:
  name: usb_out_pe

sources:
  - hw/usb_out_pkg.sv
  - hw/usb_rx_event_if.sv
  - hw/usb_out_rx_decode.sv
  - hw/usb_out_xact_fsm.sv
  - hw/usb_out_data_path.sv
  - hw/usb_out_pe.sv
  - target: simulation
    files:
      - bench/tb_usb_out_pe.sv

// ==== bench/usb_out_patterns.txt ====
// tok addr ep dpid nbytes badcrc full stall lrst gap exp_tx exp_resp exp_toggle (all hex)
// exp_resp 0 none, 1 acked, 2 rollback; exp_tx 0 means no handshake; first value is the line count
12
// Plain OUT transfers on both endpoints
1 2a 1 3 4 0 0 0 0 2 2 1 2
1 2a 1 b 3 0 0 0 0 2 2 1 0
1 2a 0 3 5 0 0 0 0 2 2 1 1
// Full and stalled endpoint
1 2a 1 3 4 0 1 0 0 2 a 2 1
1 2a 1 3 2 0 0 1 0 2 e 0 1
// SETUP handling
d 2a 0 3 8 0 0 0 0 2 2 1 1
d 2a 0 3 8 0 1 0 0 2 0 0 0
d 2a 1 3 8 0 0 0 0 2 0 0 0
// Foreign address and unimplemented endpoint
1 11 0 3 2 0 0 0 0 2 0 0 0
1 2a 5 3 2 0 0 0 0 2 0 0 0
// Wrong toggle, bad CRC, then a good one
1 2a 0 b 3 0 0 0 0 2 2 2 0
1 2a 0 3 3 1 0 0 0 2 0 2 0
1 2a 0 3 6 0 0 0 0 2 2 1 1
// Data too late, then right at the edge of the window
1 2a 1 3 2 0 0 0 0 50 0 0 1
1 2a 1 3 2 0 0 0 0 44 2 1 3
// Link reset ahead of the transaction
1 2a 1 3 1 0 0 0 1 2 2 1 2
1 2a 0 3 4 0 0 0 1 2 2 1 1
// Stall wins over full on OUT
1 2a 0 b 2 0 1 1 0 2 e 0 1
